// ==== design/lsu_pkg.sv ====
package lsu_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int unsigned DATA_W = 32;          // address and data word
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable per byte lane

  //////////////////////////////////////////////////
  // shared types

  typedef logic [DATA_W-1:0]        word_t;     // address or data word
  typedef logic [BE_W-1:0]          be_t;       // byte enables
  typedef logic [$clog2(BE_W)-1:0]  offset_t;   // byte offset inside a word

  // access size, both upper codes mean byte
  typedef enum logic [1:0] {
    DT_WORD  = 2'd0,
    DT_HALF  = 2'd1,
    DT_BYTE  = 2'd2,
    DT_BYTE3 = 2'd3  // alias of byte
  } data_type_e;

  // how the upper bits of a half or byte load are filled
  typedef enum logic [1:0] {
    EXT_ZERO = 2'd0,  // zero extend
    EXT_SIGN = 2'd1,  // copy the msb of the loaded value
    EXT_ONES = 2'd2   // fill with ones
  } sign_ext_e;

  // encoding summary
  //   data_type_e  0 word, 1 half, 2/3 byte
  //   sign_ext_e   0 zero, 1 sign, 2 ones
  //
  // a misaligned word or a half at offset 3 takes two bus accesses,
  // the second one word aligned at the next address
  //
  // offsets are in bytes, lane 0 is bits 7:0 of a word
  //
  // the bus returns one read-valid per granted transfer, stores included

endpackage

// ==== design/lsu_req_prep.sv ====
`timescale 1ns/1ns

module lsu_req_prep (
  input  lsu_pkg::word_t      operand_a_i,
  input  lsu_pkg::word_t      operand_b_i,
  input  lsu_pkg::word_t      data_wdata_i,       // store data as held in the register
  input  logic                addr_useincr_i,     // a + b, else a alone
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::offset_t    data_reg_offset_i,  // where the store value sits in the register
  input  logic                data_req_i,
  input  logic                data_misaligned_i,  // second phase of a misaligned pair
  output lsu_pkg::word_t      trans_addr_o,
  output lsu_pkg::word_t      trans_wdata_o,
  output lsu_pkg::be_t        trans_be_o,
  output lsu_pkg::offset_t    addr_offset_o,
  output logic                data_misaligned_o
);

  import lsu_pkg::*;

  word_t   addr_int;   // unaligned effective address
  offset_t addr_off;
  offset_t wdata_rot;  // byte lanes to rotate the store data by

  //////////////////////////////////////////////////
  // address

  assign addr_int = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr_int[1:0];

  // second phase goes to the next word from lane 0 up
  assign trans_addr_o  = data_misaligned_i ? {addr_int[DATA_W-1:2], 2'b00} : addr_int;
  assign addr_offset_o = addr_off;  // kept for wb even in phase two

  //////////////////////////////////////////////////
  // byte enables

  always_comb begin
    trans_be_o = '0;
    case (data_type_i)
      DT_WORD: begin
        if (!data_misaligned_i) begin
          trans_be_o = be_t'(4'b1111 << addr_off);  // lanes from offset upward
        end else begin
          // remaining low lanes of the next word, none at offset 0
          trans_be_o = be_t'(4'b1111 >> (3'd4 - {1'b0, addr_off}));
        end
      end
      DT_HALF: begin
        if (!data_misaligned_i) begin
          trans_be_o = be_t'(4'b0011 << addr_off);  // offset 3 keeps lane 3 only
        end else begin
          trans_be_o = 4'b0001;  // upper byte of the half
        end
      end
      DT_BYTE, DT_BYTE3: begin
        trans_be_o = be_t'(4'b0001 << addr_off);
      end
      default: trans_be_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // store data rotation

  // register offset moves the value down, address offset moves it up
  assign wdata_rot = addr_off - data_reg_offset_i;  // wraps mod 4

  always_comb begin
    case (wdata_rot)
      2'd0:    trans_wdata_o = data_wdata_i;
      2'd1:    trans_wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2:    trans_wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: trans_wdata_o = {data_wdata_i[7:0], data_wdata_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////
  // misalignment detect

  // only the first phase can flag, the controller then reissues
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i) begin
      case (data_type_i)
        DT_WORD: data_misaligned_o = (addr_off != 2'd0);  // any non-zero offset spills
        DT_HALF: data_misaligned_o = (addr_off == 2'd3);  // only lane 3 spills
        default: data_misaligned_o = 1'b0;                // bytes never cross
      endcase
    end
  end

endmodule

// ==== design/lsu_bus_fsm.sv ====
`timescale 1ns/1ns

module lsu_bus_fsm (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           trans_valid_i,
  input  lsu_pkg::word_t trans_addr_i,
  input  lsu_pkg::word_t trans_wdata_i,
  input  lsu_pkg::be_t   trans_be_i,
  input  logic           trans_we_i,
  input  logic           data_gnt_i,
  output logic           trans_ready_o,  // high while idle
  output logic           data_req_o,
  output lsu_pkg::word_t data_addr_o,
  output lsu_pkg::word_t data_wdata_o,
  output lsu_pkg::be_t   data_be_o,
  output logic           data_we_o
);

  import lsu_pkg::*;

  typedef enum logic {
    IDLE     = 1'b0,  // transaction passes straight to the bus
    WAIT_GNT = 1'b1   // replay the captured copy until granted
  } state_e;

  state_e state_q, state_d;
  logic   idle;

  // copy of the offered transaction, held while the grant is pending
  word_t  addr_q;
  word_t  wdata_q;
  be_t    be_q;
  logic   we_q;

  assign idle = (state_q == IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (trans_valid_i && !data_gnt_i) state_d = WAIT_GNT;  // not taken at once
      WAIT_GNT: if (data_gnt_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // sample every idle cycle, the last sample is the one left ungranted
  always_ff @(posedge clk) begin
    if (idle) begin
      addr_q  <= trans_addr_i;
      wdata_q <= trans_wdata_i;
      be_q    <= trans_be_i;
      we_q    <= trans_we_i;
    end
  end

  assign trans_ready_o = idle;
  assign data_req_o    = idle ? trans_valid_i : 1'b1;  // request stays up while waiting
  assign data_addr_o   = idle ? trans_addr_i  : addr_q;
  assign data_wdata_o  = idle ? trans_wdata_i : wdata_q;
  assign data_be_o     = idle ? trans_be_i    : be_q;
  assign data_we_o     = idle ? trans_we_i    : we_q;

endmodule

// ==== design/lsu_outstanding_cnt.sv ====
`timescale 1ns/1ns

module lsu_outstanding_cnt #(
  parameter int DEPTH = 2  // max transfers in flight
) (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_i,     // ex stage wants a transfer
  input  logic trans_ready_i,  // bus fsm can take one
  input  logic resp_valid_i,   // one response retires one transfer
  output logic trans_valid_o,
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic ctrl_update_o,  // ex/wb control registers advance
  output logic busy_o
);

  localparam int               CNT_W   = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH);

  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             count_up;    // accepted this cycle
  logic             count_down;  // answered this cycle

  // no path from read-valid to the request
  assign trans_valid_o = data_req_i && (cnt_q < CNT_MAX);

  assign count_up   = trans_valid_o && trans_ready_i;
  assign count_down = resp_valid_i;

  always_comb begin
    cnt_d = cnt_q;
    if (count_up && !count_down) cnt_d = cnt_q + 1'b1;
    else if (!count_up && count_down) cnt_d = cnt_q - 1'b1;  // both at once cancel
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // wb free when empty, else once its response shows up
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : resp_valid_i;

  // ex and wb move in lock step once wb holds something
  always_comb begin
    if (!data_req_i) lsu_ready_ex_o = 1'b1;
    else if (cnt_q == '0) lsu_ready_ex_o = count_up;
    else if (cnt_q < CNT_MAX) lsu_ready_ex_o = count_up && resp_valid_i;
    else lsu_ready_ex_o = resp_valid_i;  // full, wait for room
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_i;
  assign busy_o        = (cnt_q != '0) || trans_valid_o;

endmodule

// ==== design/lsu_load_align.sv ====
`timescale 1ns/1ns

module lsu_load_align (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ctrl_update_i,         // take over the ex stage control
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::sign_ext_e  data_sign_ext_i,
  input  logic                data_we_i,
  input  lsu_pkg::offset_t    addr_offset_i,
  input  logic                data_misaligned_ex_i,  // second phase in ex
  input  logic                data_misaligned_i,     // first phase flagged in ex
  input  logic                resp_valid_i,
  input  lsu_pkg::word_t      resp_rdata_i,
  output lsu_pkg::word_t      data_rdata_o
);

  import lsu_pkg::*;

  // wb copy of the access that is waiting for its response
  data_type_e type_q;
  sign_ext_e  ext_q;
  offset_t    offset_q;
  logic       we_q;

  word_t      rdata_q;   // first half of a split load, else last result
  word_t      rdata_w;
  word_t      rdata_h;
  word_t      rdata_b;
  word_t      rdata_ext;
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;

  // fill bit for the upper part of a half or byte
  function automatic logic ext_bit(input sign_ext_e mode, input logic msb);
    logic fill;
    case (mode)
      EXT_ZERO: fill = 1'b0;
      EXT_ONES: fill = 1'b1;
      EXT_SIGN: fill = msb;
      default:  fill = msb;  // code 3 treated as sign
    endcase
    return fill;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      type_q   <= DT_WORD;
      ext_q    <= EXT_ZERO;
      offset_q <= '0;
      we_q     <= 1'b0;
    end else if (ctrl_update_i) begin
      type_q   <= data_type_i;
      ext_q    <= data_sign_ext_i;
      offset_q <= addr_offset_i;
      we_q     <= data_we_i;
    end
  end

  //////////////////////////////////////////////////
  // alignment and extension

  // word, upper bytes of the first response below the new low bytes
  always_comb begin
    case (offset_q)
      2'd0:    rdata_w = resp_rdata_i;
      2'd1:    rdata_w = {resp_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {resp_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {resp_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (offset_q)
      2'd0:    half_sel = resp_rdata_i[15:0];
      2'd1:    half_sel = resp_rdata_i[23:8];
      2'd2:    half_sel = resp_rdata_i[31:16];
      default: half_sel = {resp_rdata_i[7:0], rdata_q[31:24]};  // crosses the word
    endcase
  end

  assign byte_sel = resp_rdata_i[{offset_q, 3'b000} +: 8];

  assign rdata_h = {{16{ext_bit(ext_q, half_sel[15])}}, half_sel};
  assign rdata_b = {{24{ext_bit(ext_q, byte_sel[7])}}, byte_sel};

  always_comb begin
    case (type_q)
      DT_WORD: rdata_ext = rdata_w;
      DT_HALF: rdata_ext = rdata_h;
      default: rdata_ext = rdata_b;  // both byte codes
    endcase
  end

  // raw word during a split first phase, final value otherwise
  always_ff @(posedge clk) begin
    if (resp_valid_i && !we_q) begin
      if (data_misaligned_ex_i || data_misaligned_i) rdata_q <= resp_rdata_i;
      else rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_o = resp_valid_i ? rdata_ext : rdata_q;  // live in the read-valid cycle

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
  parameter int DEPTH = 2  // max outstanding bus transfers
) (
  input  logic                clk,
  input  logic                rst_n,

  // ex stage request
  input  logic                data_req_ex_i,
  input  logic                data_we_ex_i,
  input  lsu_pkg::data_type_e data_type_ex_i,
  input  lsu_pkg::sign_ext_e  data_sign_ext_ex_i,
  input  lsu_pkg::word_t      data_wdata_ex_i,
  input  lsu_pkg::offset_t    data_reg_offset_ex_i,
  input  lsu_pkg::word_t      operand_a_ex_i,
  input  lsu_pkg::word_t      operand_b_ex_i,
  input  logic                addr_useincr_ex_i,
  input  logic                data_misaligned_ex_i,  // second access of a pair

  // ex stage results
  output lsu_pkg::word_t      data_rdata_ex_o,
  output logic                data_misaligned_o,     // to controller
  output logic                lsu_ready_ex_o,
  output logic                lsu_ready_wb_o,
  output logic                busy_o,

  // data bus
  output logic                data_req_o,
  output lsu_pkg::word_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::word_t      data_wdata_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  lsu_pkg::word_t      data_rdata_i
);

  import lsu_pkg::*;

  // transaction offered to the bus fsm
  word_t   trans_addr;
  word_t   trans_wdata;
  be_t     trans_be;
  logic    trans_valid;
  logic    trans_ready;

  offset_t addr_offset;  // byte offset for the wb alignment
  logic    ctrl_update;  // ex/wb control registers advance

  // address, byte enables, store data, misalignment
  lsu_req_prep i_lsu_req_prep (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .data_wdata_i      (data_wdata_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_misaligned_i (data_misaligned_ex_i),
    .trans_addr_o      (trans_addr),
    .trans_wdata_o     (trans_wdata),
    .trans_be_o        (trans_be),
    .addr_offset_o     (addr_offset),
    .data_misaligned_o (data_misaligned_o)
  );

  // request/grant side of the bus
  lsu_bus_fsm i_lsu_bus_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_addr_i  (trans_addr),
    .trans_wdata_i (trans_wdata),
    .trans_be_i    (trans_be),
    .trans_we_i    (data_we_ex_i),
    .data_gnt_i    (data_gnt_i),
    .trans_ready_o (trans_ready),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_be_o     (data_be_o),
    .data_we_o     (data_we_o)
  );

  // bus read-valid is the response strobe, no adapter in between
  lsu_outstanding_cnt #(
    .DEPTH (DEPTH)
  ) i_lsu_outstanding_cnt (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_i     (data_req_ex_i),
    .trans_ready_i  (trans_ready),
    .resp_valid_i   (data_rvalid_i),
    .trans_valid_o  (trans_valid),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .ctrl_update_o  (ctrl_update),
    .busy_o         (busy_o)
  );

  lsu_load_align i_lsu_load_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_type_i          (data_type_ex_i),
    .data_sign_ext_i      (data_sign_ext_ex_i),
    .data_we_i            (data_we_ex_i),
    .addr_offset_i        (addr_offset),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .resp_valid_i         (data_rvalid_i),
    .resp_rdata_i         (data_rdata_i),
    .data_rdata_o         (data_rdata_ex_o)
  );

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;

  import lsu_pkg::*;

  localparam int DEPTH    = 2;
  localparam int MAX_WAIT = 64;  // cycles allowed per wait loop

  typedef struct {
    string      name;
    logic       we;
    data_type_e size;
    sign_ext_e  ext;
    word_t      opa;
    word_t      opb;
    logic       incr;
    word_t      wdata;
    word_t      exp;   // filled in when the entry is applied
  } access_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  data_type_e data_type_ex_i;
  sign_ext_e  data_sign_ext_ex_i;
  word_t      data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  offset_t    data_reg_offset_ex_i;
  word_t      data_rdata_ex_o;
  logic       data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic       data_req_o, data_we_o;
  logic       data_gnt_i    = 1'b0;  // bus side idle until the responder takes over
  logic       data_rvalid_i = 1'b0;
  word_t      data_addr_o, data_wdata_o;
  word_t      data_rdata_i  = '0;
  be_t        data_be_o;

  int         errors = 0;
  integer     seed   = 32'h97e4;
  access_t    tbl[$];

  // bus side model
  word_t      mem [64];
  logic [7:0] ref_bytes [256];   // own image, byte addressed
  word_t      resp_q[$];          // read data waiting for read-valid
  logic       hold_gnt = 1'b0;
  logic       hold_rv  = 1'b0;
  logic [1:0] gnt_wait;
  logic       xfer = 1'b0;        // handshake seen at the last negedge
  logic       req_seen = 1'b0;
  word_t      x_addr, x_wdata;
  be_t        x_be;
  logic       x_we;
  int         xfer_count = 0;

  // expected bus transfers, in grant order
  string      bq_name[$];
  word_t      bq_addr[$], bq_wdata[$];
  be_t        bq_be[$];
  logic       bq_we[$];

  // expected responses, in order
  string      rq_name[$];
  word_t      rq_val[$];
  logic       rq_chk[$];

  always #4 clk = ~clk;

  lsu_top #(
    .DEPTH (DEPTH)
  ) i_lsu_top (.*);

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // reference rules

  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9e3779b1) ^ 32'h6b2fc035;  // every address bit matters
  endfunction

  function automatic int byte_count(input data_type_e size);
    case (size)
      DT_WORD: return 4;
      DT_HALF: return 2;
      default: return 1;
    endcase
  endfunction

  // lanes of the access, upper half is what spills into the next word
  function automatic be_t lanes_for(input data_type_e size, input offset_t off, input logic upper);
    logic [7:0] span;
    case (size)
      DT_WORD: span = 8'h0f;
      DT_HALF: span = 8'h03;
      default: span = 8'h01;
    endcase
    span = span << off;
    return upper ? span[7:4] : span[3:0];
  endfunction

  function automatic word_t rotate_up(input word_t w, input offset_t off);
    logic [63:0] dbl;
    int          k;
    dbl = {w, w};
    k   = 8 * int'(off);
    return dbl[63 - k -: 32];
  endfunction

  function automatic word_t expect_load(input word_t addr, input data_type_e size,
                                        input sign_ext_e ext);
    word_t      v;
    logic [7:0] ba;
    logic       fill;
    int         n;
    int         i;
    v = '0;
    n = byte_count(size);
    for (i = 0; i < n; i++) begin
      ba = addr[7:0] + 8'(i);  // little endian, may cross into the next word
      v[8*i +: 8] = ref_bytes[ba];
    end
    case (ext)
      EXT_ZERO: fill = 1'b0;
      EXT_ONES: fill = 1'b1;
      default:  fill = v[8*n-1];
    endcase
    for (i = 8 * n; i < 32; i++) v[i] = fill;
    return v;
  endfunction

  task automatic store_ref(input word_t addr, input word_t wdata, input int n);
    logic [7:0] ba;
    int         i;
    for (i = 0; i < n; i++) begin
      ba = addr[7:0] + 8'(i);
      ref_bytes[ba] = wdata[8*i +: 8];
    end
  endtask

  //////////////////////////////////////////////////
  // ex side drivers

  task automatic offer(input access_t a, input word_t opa, input logic phase, input word_t baddr,
                       input be_t bbe, input word_t bwd, input logic chk);
    @(posedge clk);
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= a.we;
    data_type_ex_i       <= a.size;
    data_sign_ext_ex_i   <= a.ext;
    data_wdata_ex_i      <= a.wdata;
    operand_a_ex_i       <= opa;
    operand_b_ex_i       <= a.opb;
    addr_useincr_ex_i    <= a.incr;
    data_misaligned_ex_i <= phase;  // controller role
    bq_name.push_back(a.name);
    bq_addr.push_back(baddr);
    bq_be.push_back(bbe);
    bq_wdata.push_back(bwd);
    bq_we.push_back(a.we);
    rq_name.push_back(a.name);
    rq_val.push_back(a.exp);
    rq_chk.push_back(chk);
  endtask

  task automatic wait_ready(input string name);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!lsu_ready_ex_o && n < MAX_WAIT);
    if (!lsu_ready_ex_o) begin
      $display("timeout: %s was never accepted by the lsu", name);
      errors++;
    end
  endtask

  task automatic release_req();
    @(posedge clk);
    data_req_ex_i        <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while (rq_name.size() != 0 && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (rq_name.size() != 0) begin
      $display("timeout: %0d responses never came back", rq_name.size());
      errors++;
    end
  endtask

  // one table entry, split into two bus accesses when it crosses a word
  task automatic run_access(input access_t a);
    word_t   addr;
    offset_t off;
    logic    split;
    word_t   wd_bus;
    addr   = a.incr ? a.opa + a.opb : a.opa;
    off    = addr[1:0];
    split  = (a.size == DT_WORD && off != 2'd0) || (a.size == DT_HALF && off == 2'd3);
    wd_bus = rotate_up(a.wdata, off);
    if (a.we) store_ref(addr, a.wdata, byte_count(a.size));
    a.exp = a.we ? '0 : expect_load(addr, a.size, a.ext);
    offer(a, a.opa, 1'b0, addr, lanes_for(a.size, off, 1'b0), wd_bus, !a.we && !split);
    wait_ready(a.name);
    check_bit({a.name, " misaligned"}, split, data_misaligned_o);
    if (split) begin
      // second half goes to the next word from lane 0
      offer(a, a.opa + 32'd4, 1'b1, (addr + 32'd4) & 32'hffff_fffc,
            lanes_for(a.size, off, 1'b1), wd_bus, !a.we);
      wait_ready(a.name);
      check_bit({a.name, " phase 2 misaligned"}, 1'b0, data_misaligned_o);
    end
    release_req();
  endtask

  task automatic add(input string name, input logic we, input data_type_e size,
                     input sign_ext_e ext, input word_t opa, input word_t opb,
                     input logic incr, input word_t wdata);
    access_t e;
    e.name  = name;
    e.we    = we;
    e.size  = size;
    e.ext   = ext;
    e.opa   = opa;
    e.opb   = opb;
    e.incr  = incr;
    e.wdata = wdata;
    e.exp   = '0;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // stores of every size and offset, then read back as words
    add("sw off0",       1, DT_WORD,  EXT_ZERO, 32'h40, 0, 1, 32'h11223344);
    add("sh off0",       1, DT_HALF,  EXT_ZERO, 32'h44, 0, 1, 32'h0000a1b2);
    add("sh off2",       1, DT_HALF,  EXT_ZERO, 32'h44, 2, 1, 32'h0000c3d4);
    add("sb off0",       1, DT_BYTE,  EXT_ZERO, 32'h48, 0, 1, 32'h000000e1);
    add("sb off1",       1, DT_BYTE,  EXT_ZERO, 32'h48, 1, 1, 32'h000000e2);
    add("sb off2",       1, DT_BYTE3, EXT_ZERO, 32'h48, 2, 1, 32'h000000e3);
    add("sb off3",       1, DT_BYTE,  EXT_ZERO, 32'h48, 3, 1, 32'h000000e4);
    add("sh off1",       1, DT_HALF,  EXT_ZERO, 32'h4c, 1, 1, 32'h00005a6b);
    add("sw off1 split", 1, DT_WORD,  EXT_ZERO, 32'h50, 1, 1, 32'hdeadbeef);
    add("sh off3 split", 1, DT_HALF,  EXT_ZERO, 32'h58, 3, 1, 32'h0000cafe);
    add("sw off3 split", 1, DT_WORD,  EXT_ZERO, 32'h64, 3, 1, 32'h8badf00d);
    add("lw 0x40",       0, DT_WORD,  EXT_ZERO, 32'h40, 0, 1, 0);
    add("lw 0x44",       0, DT_WORD,  EXT_ZERO, 32'h44, 0, 1, 0);
    add("lw 0x48",       0, DT_WORD,  EXT_ZERO, 32'h48, 0, 1, 0);
    add("lw 0x4c",       0, DT_WORD,  EXT_ZERO, 32'h4c, 0, 1, 0);
    add("lw 0x50",       0, DT_WORD,  EXT_ZERO, 32'h50, 0, 1, 0);
    add("lw 0x54",       0, DT_WORD,  EXT_ZERO, 32'h54, 0, 1, 0);
    add("lw 0x58",       0, DT_WORD,  EXT_ZERO, 32'h58, 0, 1, 0);
    add("lw 0x5c",       0, DT_WORD,  EXT_ZERO, 32'h5c, 0, 1, 0);
    add("lw 0x64",       0, DT_WORD,  EXT_ZERO, 32'h64, 0, 1, 0);
    add("lw 0x68",       0, DT_WORD,  EXT_ZERO, 32'h68, 0, 1, 0);
    // byte and half loads from the fill pattern
    add("lb off0 zero",  0, DT_BYTE,  EXT_ZERO, 32'h80, 0, 1, 0);
    add("lb off1 sign",  0, DT_BYTE,  EXT_SIGN, 32'h80, 1, 1, 0);
    add("lb off2 ones",  0, DT_BYTE,  EXT_ONES, 32'h80, 2, 1, 0);
    add("lb off3 sign",  0, DT_BYTE3, EXT_SIGN, 32'h84, 3, 1, 0);
    add("lb a only",     0, DT_BYTE,  EXT_SIGN, 32'h89, 32'h100, 0, 0);  // b ignored
    add("lh off0 zero",  0, DT_HALF,  EXT_ZERO, 32'h8c, 0, 1, 0);
    add("lh off0 sign",  0, DT_HALF,  EXT_SIGN, 32'h90, 0, 1, 0);
    add("lh off1 sign",  0, DT_HALF,  EXT_SIGN, 32'h94, 1, 1, 0);
    add("lh off2 ones",  0, DT_HALF,  EXT_ONES, 32'h98, 2, 1, 0);
    add("lh off2 sign",  0, DT_HALF,  EXT_SIGN, 32'h9c, 2, 1, 0);
    // loads that cross a word
    add("lw off1 split", 0, DT_WORD,  EXT_ZERO, 32'ha0, 1, 1, 0);
    add("lw off2 split", 0, DT_WORD,  EXT_ZERO, 32'ha4, 2, 1, 0);
    add("lw off3 split", 0, DT_WORD,  EXT_ZERO, 32'ha8, 3, 1, 0);
    add("lh off3 sign",  0, DT_HALF,  EXT_SIGN, 32'hac, 3, 1, 0);
    add("lh off3 zero",  0, DT_HALF,  EXT_ZERO, 32'hb0, 3, 1, 0);
  endtask

  //////////////////////////////////////////////////
  // bus monitor and responder

  always @(negedge clk) begin : bus_monitor
    string nm;
    if (rst_n) begin
      xfer     = data_req_o && data_gnt_i;
      req_seen = data_req_o;
      if (xfer) begin
        xfer_count++;
        x_addr  = data_addr_o;
        x_wdata = data_wdata_o;
        x_be    = data_be_o;
        x_we    = data_we_o;
        if (bq_name.size() == 0) begin
          $display("bus transfer at %h with no access pending", data_addr_o);
          errors++;
        end else begin
          nm = bq_name.pop_front();
          check_word({nm, " bus addr"}, bq_addr.pop_front(), data_addr_o);
          check_be({nm, " bus be"}, bq_be.pop_front(), data_be_o);
          check_bit({nm, " bus we"}, bq_we.pop_front(), data_we_o);
          if (data_we_o) check_word({nm, " bus wdata"}, bq_wdata.pop_front(), data_wdata_o);
          else void'(bq_wdata.pop_front());
        end
      end
      if (data_rvalid_i) begin
        if (rq_name.size() == 0) begin
          $display("read-valid with no access outstanding");
          errors++;
        end else begin
          nm = rq_name.pop_front();
          if (rq_chk.pop_front()) begin
            check_word({nm, " load data"}, rq_val.pop_front(), data_rdata_ex_o);
          end else begin
            void'(rq_val.pop_front());
          end
        end
      end
    end
  end

  // ungranted request must hold still until its grant
  always @(negedge clk) begin : stall_monitor
    logic  waiting;
    word_t p_addr, p_wdata;
    be_t   p_be;
    if (rst_n && waiting && data_req_o) begin
      check_word("stalled bus addr", p_addr, data_addr_o);
      check_be("stalled bus be", p_be, data_be_o);
      check_word("stalled bus wdata", p_wdata, data_wdata_o);
    end
    waiting = rst_n && data_req_o && !data_gnt_i;
    p_addr  = data_addr_o;
    p_wdata = data_wdata_o;
    p_be    = data_be_o;
  end

  always @(posedge clk) begin : responder
    logic [31:0] rnd;
    int          b;
    if (!rst_n) begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      data_rdata_i  <= '0;
      gnt_wait      = 2'd0;
    end else begin
      if (xfer) begin
        for (b = 0; b < 4; b++) begin
          if (x_we && x_be[b]) mem[x_addr[7:2]][8*b +: 8] = x_wdata[8*b +: 8];
        end
        resp_q.push_back(mem[x_addr[7:2]]);
        rnd      = $random(seed);
        gnt_wait = rnd[1:0];  // 0 to 3 cycles for the next grant
      end else if (req_seen && gnt_wait != 2'd0) begin
        gnt_wait = gnt_wait - 2'd1;
      end
      data_gnt_i <= (gnt_wait == 2'd0) && !hold_gnt;
      if (!hold_rv && resp_q.size() != 0) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= resp_q.pop_front();
      end else begin
        data_rvalid_i <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    access_t a;
    int      i;
    int      base;
    rst_n                = 1'b0;
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = DT_WORD;
    data_sign_ext_ex_i   = EXT_ZERO;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = '0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b1;
    data_misaligned_ex_i = 1'b0;
    for (i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
      ref_bytes[4*i]   = mem[i][7:0];
      ref_bytes[4*i+1] = mem[i][15:8];
      ref_bytes[4*i+2] = mem[i][23:16];
      ref_bytes[4*i+3] = mem[i][31:24];
    end
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("reset data_req_o", 1'b0, data_req_o);
    check_bit("reset busy_o", 1'b0, busy_o);
    check_bit("reset ready_ex", 1'b1, lsu_ready_ex_o);
    check_bit("reset ready_wb", 1'b1, lsu_ready_wb_o);
    check_bit("reset misaligned", 1'b0, data_misaligned_o);

    foreach (tbl[i]) run_access(tbl[i]);

    // grant withheld, store sits in the fsm and the next load waits
    drain_responses();
    hold_gnt = 1'b1;
    add("sw stall", 1, DT_WORD, EXT_ZERO, 32'h70, 0, 1, 32'h0f1e2d3c);
    add("lw stall", 0, DT_WORD, EXT_ZERO, 32'h70, 0, 1, 0);
    a = tbl[tbl.size()-2];
    store_ref(32'h70, a.wdata, 4);
    offer(a, a.opa, 1'b0, 32'h70, 4'hf, a.wdata, 1'b0);
    wait_ready(a.name);
    a     = tbl[tbl.size()-1];
    a.exp = expect_load(32'h70, DT_WORD, EXT_ZERO);
    offer(a, a.opa, 1'b0, 32'h70, 4'hf, a.wdata, 1'b1);
    repeat (6) begin
      @(negedge clk);
      check_bit("grant stall ready_ex", 1'b0, lsu_ready_ex_o);
      check_bit("grant stall data_req_o", 1'b1, data_req_o);
    end
    hold_gnt = 1'b0;
    wait_ready(a.name);
    release_req();

    // read-valid withheld, at most DEPTH transfers go out
    drain_responses();
    hold_rv = 1'b1;
    base    = xfer_count;
    add("lw held", 0, DT_WORD, EXT_ZERO, 32'h84, 0, 1, 0);
    add("lh held", 0, DT_HALF, EXT_SIGN, 32'h88, 2, 1, 0);
    a     = tbl[tbl.size()-2];
    a.exp = expect_load(32'h84, DT_WORD, EXT_ZERO);
    offer(a, a.opa, 1'b0, 32'h84, 4'hf, a.wdata, 1'b1);
    wait_ready(a.name);
    a     = tbl[tbl.size()-1];
    a.exp = expect_load(32'h8a, DT_HALF, EXT_SIGN);
    offer(a, a.opa, 1'b0, 32'h8a, 4'b1100, rotate_up(a.wdata, 2'd2), 1'b1);
    repeat (12) begin
      @(negedge clk);
      check_bit("rvalid stall busy_o", 1'b1, busy_o);
      check_bit("rvalid stall ready_ex", 1'b0, lsu_ready_ex_o);
      check_bit("rvalid stall within depth", 1'b1, (xfer_count - base) <= DEPTH);
    end
    check_bit("rvalid stall reached depth", 1'b1, (xfer_count - base) == DEPTH);
    hold_rv = 1'b0;
    wait_ready(a.name);
    release_req();
    drain_responses();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== lsu_top.f ====
design/lsu_pkg.sv
design/lsu_req_prep.sv
design/lsu_bus_fsm.sv
design/lsu_outstanding_cnt.sv
design/lsu_load_align.sv
design/lsu_top.sv
sim/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the lsu testbench with verilator and run it
set -u
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f lsu_top.f --top-module lsu_tb -o lsu_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/lsu_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
